//--- all.f
+incdir+common
common/fetch_pkg.sv
rtl/pc_gen.sv
bpu/bpu.sv
rtl/fetch_reg.sv
rtl/predecoder.sv
ififo/inst_queue.sv
rtl/inst_fetch.sv
verification/inst_fetch_tb.sv

//--- bpu/bpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module bpu
    import fetch_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire addr_t  pc,
    input  wire         upd_valid,
    input  wire         upd_taken,
    input  wire addr_t  upd_pc,
    input  wire addr_t  upd_target,
    output logic        taken,
    output addr_t       target,
    output logic        slot_valid [`FETCH_WIDTH]
);

    localparam int W      = `FETCH_WIDTH;
    localparam int SLOT_W = $clog2(W);
    localparam int IDX_W  = $clog2(`BTB_ENTRIES);
    localparam int TAG_W  = 30 - IDX_W;

    logic               btb_valid  [`BTB_ENTRIES];
    logic [TAG_W-1:0]   btb_tag    [`BTB_ENTRIES];
    addr_t              btb_target [`BTB_ENTRIES];
    ctr_t               btb_ctr    [`BTB_ENTRIES];

    logic [SLOT_W-1:0]  start;
    logic [IDX_W-1:0]   slot_idx [W];
    logic               slot_hit [W];
    logic [IDX_W-1:0]   upd_idx;
    logic               upd_hit;

    // first slot of the packet that is actually fetched
    assign start = pc[SLOT_W+1:2];

    for (genvar i = 0; i < W; i++) begin : g_lookup
        addr_t slot_pc;
        assign slot_pc     = {pc[31:SLOT_W+2], SLOT_W'(i), 2'b00};
        assign slot_idx[i] = slot_pc[IDX_W+1:2];
        assign slot_hit[i] = (i >= int'(start)) && btb_valid[slot_idx[i]]
                             && (btb_tag[slot_idx[i]] == slot_pc[31:IDX_W+2])
                             && btb_ctr[slot_idx[i]][1];
    end

    // lowest taken slot wins, later slots dropped
    always_comb begin
        logic seen;
        seen   = 1'b0;
        taken  = 1'b0;
        target = '0;
        for (int i = 0; i < W; i++) begin
            slot_valid[i] = (i >= int'(start)) && !seen;
            if (slot_hit[i] && !seen) begin
                taken  = 1'b1;
                target = btb_target[slot_idx[i]];
            end
            seen = seen | slot_hit[i];
        end
    end

    assign upd_idx = upd_pc[IDX_W+1:2];
    assign upd_hit = btb_valid[upd_idx] && (btb_tag[upd_idx] == upd_pc[31:IDX_W+2]);

    always_ff @(posedge clk) begin
        if (reset) begin
            btb_valid <= '{default: 1'b0};
        end else if (upd_valid && upd_taken && !upd_hit) begin
            btb_valid[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid && upd_hit) begin
            if (upd_taken) begin
                btb_target[upd_idx] <= upd_target;
                if (btb_ctr[upd_idx] != 2'b11) begin
                    btb_ctr[upd_idx] <= btb_ctr[upd_idx] + 2'b01;
                end
            end else if (btb_ctr[upd_idx] != 2'b00) begin
                btb_ctr[upd_idx] <= btb_ctr[upd_idx] - 2'b01;
            end
        end else if (upd_valid && upd_taken) begin
            // new entry starts weakly taken
            btb_tag[upd_idx]    <= upd_pc[31:IDX_W+2];
            btb_target[upd_idx] <= upd_target;
            btb_ctr[upd_idx]    <= 2'b10;
        end
    end

endmodule

`default_nettype wire

//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // byte address
    typedef logic [31:0] addr_t;

    typedef logic [31:0] inst_t;

    typedef logic [4:0] excp_code_t;

    // saturating counter, msb set means taken
    typedef logic [1:0] ctr_t;

endpackage

`default_nettype wire

//--- common/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// instructions per packet, packets aligned to 4 * FETCH_WIDTH bytes
`define FETCH_WIDTH 2

// legal instruction window
`define IMEM_MIN 32'h1c00_0000
`define IMEM_MAX 32'h1c00_0fff

`define RESET_PC 32'h1c00_0000

// direct mapped, indexed by word address bits
`define BTB_ENTRIES 16

`define IQ_DEPTH 8

// fetch address error
`define ADEF 5'h08

`endif

//--- ififo/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module inst_queue
    import fetch_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         flush,
    input  wire         stall_dec,
    input  wire         in_valid [`FETCH_WIDTH],
    input  wire addr_t  in_pc,
    input  wire inst_t  in_inst [`FETCH_WIDTH],
    input  wire         in_is_branch [`FETCH_WIDTH],
    input  wire         in_pred_taken [`FETCH_WIDTH],
    input  wire addr_t  in_target [`FETCH_WIDTH],
    input  wire         in_excp,
    output logic        full,
    output logic        out_valid [`FETCH_WIDTH],
    output addr_t       out_pc [`FETCH_WIDTH],
    output inst_t       out_inst [`FETCH_WIDTH],
    output logic        out_is_branch [`FETCH_WIDTH],
    output logic        out_pred_taken [`FETCH_WIDTH],
    output addr_t       out_target [`FETCH_WIDTH],
    output logic        out_has_excp [`FETCH_WIDTH],
    output excp_code_t  out_excp_code [`FETCH_WIDTH]
);

    localparam int W      = `FETCH_WIDTH;
    localparam int DEPTH  = `IQ_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int SLOT_W = $clog2(W);

    addr_t  q_pc         [DEPTH];
    inst_t  q_inst       [DEPTH];
    logic   q_is_branch  [DEPTH];
    logic   q_pred_taken [DEPTH];
    addr_t  q_target     [DEPTH];
    logic   q_excp       [DEPTH];

    logic [PTR_W-1:0]   wptr;
    logic [PTR_W-1:0]   rptr;
    logic [PTR_W:0]     count;
    logic [PTR_W:0]     n_in;
    logic [PTR_W:0]     n_out;
    logic [PTR_W-1:0]   waddr [W];

    assign full = count > (PTR_W + 1)'(DEPTH - W);

    // valid slots packed together in order
    always_comb begin
        n_in  = '0;
        n_out = '0;
        for (int i = 0; i < W; i++) begin
            waddr[i] = wptr + n_in[PTR_W-1:0];
            n_in     = n_in + (PTR_W + 1)'(in_valid[i]);
            if (!stall_dec && out_valid[i]) begin
                n_out = n_out + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            wptr  <= wptr + (full ? '0 : n_in[PTR_W-1:0]);
            rptr  <= rptr + n_out[PTR_W-1:0];
            count <= count + (full ? '0 : n_in) - n_out;
        end
    end

    always_ff @(posedge clk) begin
        if (!full) begin
            for (int i = 0; i < W; i++) begin
                if (in_valid[i]) begin
                    q_pc[waddr[i]]         <= {in_pc[31:SLOT_W+2], SLOT_W'(i), 2'b00};
                    q_inst[waddr[i]]       <= in_inst[i];
                    q_is_branch[waddr[i]]  <= in_is_branch[i];
                    q_pred_taken[waddr[i]] <= in_pred_taken[i];
                    q_target[waddr[i]]     <= in_target[i];
                    q_excp[waddr[i]]       <= in_excp;
                end
            end
        end
    end

    for (genvar i = 0; i < W; i++) begin : g_out
        logic [PTR_W-1:0] raddr;
        assign raddr             = rptr + PTR_W'(i);
        assign out_valid[i]      = count > (PTR_W + 1)'(i);
        assign out_pc[i]         = q_pc[raddr];
        assign out_inst[i]       = q_inst[raddr];
        assign out_is_branch[i]  = q_is_branch[raddr];
        assign out_pred_taken[i] = q_pred_taken[raddr];
        assign out_target[i]     = q_target[raddr];
        assign out_has_excp[i]   = q_excp[raddr];
        assign out_excp_code[i]  = q_excp[raddr] ? `ADEF : 5'h00;
    end

endmodule

`default_nettype wire

//--- rtl/fetch_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_reg
    import fetch_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         flush,
    input  wire         kill,
    input  wire         hold,
    input  wire addr_t  pc,
    input  wire         mem_rd,
    input  wire         slot_valid_in [`FETCH_WIDTH],
    input  wire         pred_taken_in [`FETCH_WIDTH],
    input  wire addr_t  pred_target_in,
    output addr_t       pc_r,
    output logic        excp_r,
    output logic        slot_valid_r [`FETCH_WIDTH],
    output logic        pred_taken_r [`FETCH_WIDTH],
    output addr_t       pred_target_r
);

    logic drop;
    logic load;

    assign drop = flush | kill;
    assign load = drop | ~hold;

    // pc_r and excp_r always describe the same address, even for an empty packet
    always_ff @(posedge clk) begin
        if (reset) begin
            excp_r       <= 1'b0;
            slot_valid_r <= '{default: 1'b0};
            pred_taken_r <= '{default: 1'b0};
        end else if (load) begin
            excp_r <= ~mem_rd;
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                slot_valid_r[i] <= slot_valid_in[i] & ~drop;
                pred_taken_r[i] <= pred_taken_in[i] & ~drop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pc_r          <= pc;
            pred_target_r <= pred_target_in;
        end
    end

endmodule

`default_nettype wire

//--- rtl/inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module inst_fetch
    import fetch_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         stall_dec,
    input  wire         excp_req,
    input  wire addr_t  excp_target,
    input  wire         ertn_req,
    input  wire addr_t  ertn_target,
    input  wire         rob_redirect,
    input  wire addr_t  rob_target,
    input  wire         rob_valid,
    input  wire         rob_is_branch,
    input  wire         rob_taken,
    input  wire addr_t  rob_pc,
    input  wire inst_t  inst [`FETCH_WIDTH],
    output addr_t       pc_imem,
    output logic        mem_rd,
    output logic        jump,
    output logic        full,
    output logic        out_valid [`FETCH_WIDTH],
    output addr_t       out_pc [`FETCH_WIDTH],
    output inst_t       out_inst [`FETCH_WIDTH],
    output logic        out_is_branch [`FETCH_WIDTH],
    output logic        out_pred_taken [`FETCH_WIDTH],
    output addr_t       out_target [`FETCH_WIDTH],
    output logic        out_has_excp [`FETCH_WIDTH],
    output excp_code_t  out_excp_code [`FETCH_WIDTH]
);

    localparam int W         = `FETCH_WIDTH;
    localparam int PKT_BYTES = W * 4;

    addr_t  pc;
    logic   pc_rd;
    logic   bpu_taken;
    addr_t  bpu_target;
    logic   slot_valid [W];
    logic   pred_taken [W];
    addr_t  pc_r;
    logic   excp_r;
    logic   slot_valid_r [W];
    logic   pred_taken_r [W];
    addr_t  pred_target_r;
    logic   pd_redirect;
    addr_t  pd_target;
    logic   valid_inst [W];
    logic   is_branch [W];
    addr_t  branch_target [W];
    logic   backend_flush;
    logic   upd_valid;

    assign backend_flush = excp_req | ertn_req | rob_redirect;
    assign upd_valid     = rob_valid & rob_is_branch;

    // predecode redirect only once its packet can enter the queue
    assign jump = pd_redirect & ~full;

    // while full, re-read the held packet so inst stays aligned with fetch_reg
    assign pc_imem = (full ? pc_r : pc) & ~addr_t'(PKT_BYTES - 1);
    assign mem_rd  = full ? ~excp_r : pc_rd;

    // the taken slot is the last one left valid
    for (genvar i = 0; i < W; i++) begin : g_pred
        if (i == W - 1) begin : g_last
            assign pred_taken[i] = bpu_taken & slot_valid[i];
        end else begin : g_mid
            assign pred_taken[i] = bpu_taken & slot_valid[i] & ~slot_valid[i+1];
        end
    end

    pc_gen u_pc_gen (
        .clk(clk), .reset(reset), .hold(full),
        .excp_req(excp_req), .excp_target(excp_target),
        .ertn_req(ertn_req), .ertn_target(ertn_target),
        .rob_redirect(rob_redirect), .rob_target(rob_target),
        .pd_redirect(jump), .pd_target(pd_target),
        .bpu_taken(bpu_taken), .bpu_target(bpu_target),
        .pc(pc), .mem_rd(pc_rd)
    );

    bpu u_bpu (
        .clk(clk), .reset(reset), .pc(pc),
        .upd_valid(upd_valid), .upd_taken(rob_taken),
        .upd_pc(rob_pc), .upd_target(rob_target),
        .taken(bpu_taken), .target(bpu_target), .slot_valid(slot_valid)
    );

    fetch_reg u_fetch_reg (
        .clk(clk), .reset(reset), .flush(backend_flush), .kill(jump), .hold(full),
        .pc(pc), .mem_rd(pc_rd), .slot_valid_in(slot_valid),
        .pred_taken_in(pred_taken), .pred_target_in(bpu_target),
        .pc_r(pc_r), .excp_r(excp_r), .slot_valid_r(slot_valid_r),
        .pred_taken_r(pred_taken_r), .pred_target_r(pred_target_r)
    );

    predecoder u_predecoder (
        .pc_r(pc_r), .inst(inst), .slot_valid_r(slot_valid_r),
        .pred_taken_r(pred_taken_r), .pred_target_r(pred_target_r), .excp_r(excp_r),
        .redirect(pd_redirect), .target(pd_target), .valid_inst(valid_inst),
        .is_branch(is_branch), .branch_target(branch_target)
    );

    inst_queue u_inst_queue (
        .clk(clk), .reset(reset), .flush(backend_flush), .stall_dec(stall_dec),
        .in_valid(valid_inst), .in_pc(pc_r), .in_inst(inst), .in_is_branch(is_branch),
        .in_pred_taken(pred_taken_r), .in_target(branch_target), .in_excp(excp_r),
        .full(full), .out_valid(out_valid), .out_pc(out_pc), .out_inst(out_inst),
        .out_is_branch(out_is_branch), .out_pred_taken(out_pred_taken),
        .out_target(out_target), .out_has_excp(out_has_excp),
        .out_excp_code(out_excp_code)
    );

endmodule

`default_nettype wire

//--- rtl/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module pc_gen
    import fetch_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         hold,
    input  wire         excp_req,
    input  wire addr_t  excp_target,
    input  wire         ertn_req,
    input  wire addr_t  ertn_target,
    input  wire         rob_redirect,
    input  wire addr_t  rob_target,
    input  wire         pd_redirect,
    input  wire addr_t  pd_target,
    input  wire         bpu_taken,
    input  wire addr_t  bpu_target,
    output addr_t       pc,
    output logic        mem_rd
);

    localparam int PKT_BYTES = `FETCH_WIDTH * 4;

    addr_t base;
    addr_t last_byte;

    assign base      = pc & ~addr_t'(PKT_BYTES - 1);
    assign last_byte = base + addr_t'(PKT_BYTES - 1);

    // whole packet inside the window, word aligned
    assign mem_rd = (base >= `IMEM_MIN) && (last_byte <= `IMEM_MAX) && (pc[1:0] == 2'b00);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (excp_req) begin
            pc <= excp_target;
        end else if (ertn_req) begin
            pc <= ertn_target;
        end else if (rob_redirect) begin
            pc <= rob_target;
        end else if (pd_redirect) begin
            pc <= pd_target;
        end else if (!hold) begin
            if (bpu_taken) begin
                pc <= bpu_target;
            end else begin
                pc <= base + addr_t'(PKT_BYTES);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/predecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module predecoder
    import fetch_pkg::*;
(
    input  wire addr_t  pc_r,
    input  wire inst_t  inst [`FETCH_WIDTH],
    input  wire         slot_valid_r [`FETCH_WIDTH],
    input  wire         pred_taken_r [`FETCH_WIDTH],
    input  wire addr_t  pred_target_r,
    input  wire         excp_r,
    output logic        redirect,
    output addr_t       target,
    output logic        valid_inst [`FETCH_WIDTH],
    output logic        is_branch [`FETCH_WIDTH],
    output addr_t       branch_target [`FETCH_WIDTH]
);

    localparam int W      = `FETCH_WIDTH;
    localparam int SLOT_W = $clog2(W);

    logic miss [W];

    for (genvar i = 0; i < W; i++) begin : g_slot
        logic [5:0] op;
        logic       is_jump;
        logic       is_cond;
        addr_t      slot_pc;
        addr_t      offs26;
        addr_t      offs16;

        assign op      = inst[i][31:26];
        assign slot_pc = {pc_r[31:SLOT_W+2], SLOT_W'(i), 2'b00};
        assign offs26  = {{4{inst[i][9]}}, inst[i][9:0], inst[i][25:10], 2'b00};
        assign offs16  = {{14{inst[i][25]}}, inst[i][25:10], 2'b00};

        // b, bl
        assign is_jump = !excp_r && (op == 6'b010100 || op == 6'b010101);
        // beq through bgeu
        assign is_cond = !excp_r && (op >= 6'b010110) && (op <= 6'b011011);

        assign is_branch[i]     = is_jump | is_cond;
        assign branch_target[i] = is_jump ? slot_pc + offs26 :
                                  is_cond ? slot_pc + offs16 : slot_pc + 32'd4;

        // jump not predicted to its target, or a taken prediction on a non-branch
        assign miss[i] = slot_valid_r[i] && !excp_r &&
                         (is_jump ? !(pred_taken_r[i] && pred_target_r == branch_target[i])
                                  : (pred_taken_r[i] && !is_cond));
    end

    always_comb begin
        logic seen;
        seen     = 1'b0;
        redirect = 1'b0;
        target   = '0;
        for (int i = 0; i < W; i++) begin
            valid_inst[i] = slot_valid_r[i] && !seen;
            if (miss[i] && !seen) begin
                redirect = 1'b1;
                target   = branch_target[i];
            end
            seen = seen | miss[i];
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the fetch testbench, exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module inst_fetch_tb -f all.f
./obj_dir/Vinst_fetch_tb

//--- verification/inst_fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module inst_fetch_tb
    import fetch_pkg::*;
();

    localparam int    W         = `FETCH_WIDTH;
    localparam int    MEM_WORDS = (`IMEM_MAX - `IMEM_MIN + 1) / 4;
    localparam int    IDX_W     = $clog2(`BTB_ENTRIES);
    localparam addr_t PKT_MASK  = addr_t'(W * 4 - 1);
    // conditional branch that the BTB learns, and its target
    localparam addr_t COND_PC   = 32'h1c00_0800;
    localparam addr_t COND_TGT  = 32'h1c00_0900;

    logic       clk           = 1'b0;
    logic       reset         = 1'b1;
    logic       stall_dec     = 1'b0;
    logic       excp_req      = 1'b0;
    addr_t      excp_target   = '0;
    logic       ertn_req      = 1'b0;
    addr_t      ertn_target   = '0;
    logic       rob_redirect  = 1'b0;
    addr_t      rob_target    = '0;
    logic       rob_valid     = 1'b0;
    logic       rob_is_branch = 1'b0;
    logic       rob_taken     = 1'b0;
    addr_t      rob_pc        = '0;
    inst_t      inst [W]      = '{default: '0};
    addr_t      pc_imem;
    logic       mem_rd;
    logic       jump;
    logic       full;
    logic       out_valid [W];
    addr_t      out_pc [W];
    inst_t      out_inst [W];
    logic       out_is_branch [W];
    logic       out_pred_taken [W];
    addr_t      out_target [W];
    logic       out_has_excp [W];
    excp_code_t out_excp_code [W];

    inst_t      mem [MEM_WORDS];
    logic [31:0] lfsr = 32'd9937;
    int         stall_mode = 0;
    int         delivered = 0;
    int         jump_pulses = 0;
    int         jumps_out = 0;
    addr_t      exp_pc = `RESET_PC;
    addr_t      bad_base = 32'h1;
    logic       saw_full = 1'b0;
    logic       saw_pred = 1'b0;
    logic       prev_hold = 1'b0;
    logic       prev_valid [W] = '{default: 1'b0};
    addr_t      prev_pc [W];
    inst_t      prev_inst [W];
    logic       btb_v [`BTB_ENTRIES] = '{default: 1'b0};
    addr_t      btb_pc [`BTB_ENTRIES];
    addr_t      btb_tgt [`BTB_ENTRIES];

    inst_fetch dut_i (
        .clk(clk), .reset(reset), .stall_dec(stall_dec),
        .excp_req(excp_req), .excp_target(excp_target),
        .ertn_req(ertn_req), .ertn_target(ertn_target),
        .rob_redirect(rob_redirect), .rob_target(rob_target),
        .rob_valid(rob_valid), .rob_is_branch(rob_is_branch), .rob_taken(rob_taken),
        .rob_pc(rob_pc), .inst(inst),
        .pc_imem(pc_imem), .mem_rd(mem_rd), .jump(jump), .full(full),
        .out_valid(out_valid), .out_pc(out_pc), .out_inst(out_inst),
        .out_is_branch(out_is_branch), .out_pred_taken(out_pred_taken),
        .out_target(out_target), .out_has_excp(out_has_excp),
        .out_excp_code(out_excp_code)
    );

    always #5 clk = ~clk;

    // galois form, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic in_window(input addr_t a);
        return (a >= `IMEM_MIN) && (a <= `IMEM_MAX);
    endfunction

    function automatic int word_index(input addr_t a);
        addr_t d;
        d = a - `IMEM_MIN;
        return int'(d >> 2);
    endfunction

    function automatic inst_t enc_jump(input logic [5:0] op, input addr_t from, input addr_t to);
        addr_t d;
        d = (to - from) >> 2;
        return {op, d[15:0], d[25:16]};
    endfunction

    function automatic inst_t enc_beq(input addr_t from, input addr_t to);
        addr_t d;
        d = (to - from) >> 2;
        return {6'h16, d[15:0], 10'h000};
    endfunction

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    // memory answers one cycle later
    always @(posedge clk) begin
        addr_t a;
        logic rd;
        a = pc_imem;
        rd = mem_rd;
        if (!reset && rd) begin
            assert (in_window(a) && in_window(a + addr_t'(4 * W - 1))) else begin
                $display("Fail mem_rd: expected %h, got %h for pc_imem %h", 1'b0, rd, a);
                stop_on_error();
            end
        end
        #1;
        for (int i = 0; i < W; i++) begin
            inst[i] = rd ? mem[word_index(a + addr_t'(4 * i))] : '0;
        end
    end

    always @(posedge clk) begin
        #1;
        if (stall_mode == 1) begin
            stall_dec = (take_bits(2) == 2'b00);
        end else if (stall_mode == 2) begin
            stall_dec = (take_bits(2) != 2'b00);
        end else begin
            stall_dec = 1'b0;
        end
    end

    task automatic check_slot(input int i);
        addr_t       p;
        addr_t       nxt;
        addr_t       tgt;
        inst_t       w;
        logic        bad;
        logic        jmp;
        logic        cnd;
        logic        hit;
        logic [25:0] o26;
        logic [15:0] o16;
        p = exp_pc;
        nxt = p + 32'd4;
        bad = !in_window(p) || ((p & ~PKT_MASK) == bad_base);
        assert (out_pc[i] == p) else begin
            $display("Fail out_pc[%0d]: expected %h, got %h", i, p, out_pc[i]);
            stop_on_error();
        end
        assert (out_has_excp[i] == bad) else begin
            $display("Fail out_has_excp[%0d]: expected %h, got %h", i, bad, out_has_excp[i]);
            stop_on_error();
        end
        if (bad) begin
            assert (out_excp_code[i] == `ADEF) else begin
                $display("Fail out_excp_code[%0d]: expected %h, got %h",
                         i, `ADEF, out_excp_code[i]);
                stop_on_error();
            end
        end else begin
            w = mem[word_index(p)];
            o26 = {w[9:0], w[25:10]};
            o16 = w[25:10];
            jmp = (w[31:26] == 6'h14) || (w[31:26] == 6'h15);
            cnd = (w[31:26] >= 6'h16) && (w[31:26] <= 6'h1b);
            hit = cnd && btb_v[p[IDX_W+1:2]] && (btb_pc[p[IDX_W+1:2]] == p);
            tgt = jmp ? p + {{4{o26[25]}}, o26, 2'b00} : p + {{14{o16[15]}}, o16, 2'b00};
            assert (out_inst[i] == w) else begin
                $display("Fail out_inst[%0d]: expected %h, got %h", i, w, out_inst[i]);
                stop_on_error();
            end
            assert (out_is_branch[i] == (jmp || cnd)) else begin
                $display("Fail out_is_branch[%0d]: expected %h, got %h",
                         i, jmp || cnd, out_is_branch[i]);
                stop_on_error();
            end
            assert (!(jmp || cnd) || out_target[i] == tgt) else begin
                $display("Fail out_target[%0d]: expected %h, got %h", i, tgt, out_target[i]);
                stop_on_error();
            end
            assert (out_pred_taken[i] == hit) else begin
                $display("Fail out_pred_taken[%0d]: expected %h, got %h",
                         i, hit, out_pred_taken[i]);
                stop_on_error();
            end
            if (jmp) begin
                nxt = tgt;
                // unpredicted jumps resolve in predecode
                jumps_out++;
                assert (jumps_out <= jump_pulses) else begin
                    $display("jump was not raised for the branch at %h", p);
                    stop_on_error();
                end
            end else if (hit) begin
                nxt = btb_tgt[p[IDX_W+1:2]];
            end
            saw_pred = saw_pred | hit;
        end
        if ((p & ~PKT_MASK) != bad_base) begin
            bad_base = 32'h1;
        end
        exp_pc = nxt;
        delivered++;
    endtask

    // outputs are stable here, consumed at the next rising edge
    always @(negedge clk) begin
        logic redir;
        redir = excp_req | ertn_req | rob_redirect;
        if (!reset) begin
            for (int i = 0; i < W; i++) begin
                if (prev_hold && prev_valid[i]) begin
                    assert (out_valid[i]) else begin
                        $display("Fail out_valid[%0d] under stall: expected %h, got %h",
                                 i, 1'b1, out_valid[i]);
                        stop_on_error();
                    end
                    assert (out_pc[i] == prev_pc[i]) else begin
                        $display("Fail out_pc[%0d] under stall: expected %h, got %h",
                                 i, prev_pc[i], out_pc[i]);
                        stop_on_error();
                    end
                    assert (out_inst[i] == prev_inst[i]) else begin
                        $display("Fail out_inst[%0d] under stall: expected %h, got %h",
                                 i, prev_inst[i], out_inst[i]);
                        stop_on_error();
                    end
                end
            end
            saw_full = saw_full | full;
            if (jump && !redir) begin
                jump_pulses++;
            end
            if (rob_valid && rob_is_branch && rob_taken) begin
                btb_v[rob_pc[IDX_W+1:2]] = 1'b1;
                btb_pc[rob_pc[IDX_W+1:2]] = rob_pc;
                btb_tgt[rob_pc[IDX_W+1:2]] = rob_target;
            end
            if (redir) begin
                // exception over ertn over rob
                if (excp_req) begin
                    exp_pc = excp_target;
                end else if (ertn_req) begin
                    exp_pc = ertn_target;
                end else begin
                    exp_pc = rob_target;
                end
                bad_base = (exp_pc[1:0] != 2'b00) ? (exp_pc & ~PKT_MASK) : 32'h1;
                exp_pc = exp_pc & ~addr_t'(3);
            end else if (!stall_dec) begin
                for (int i = 0; i < W; i++) begin
                    if (out_valid[i]) begin
                        check_slot(i);
                    end
                end
            end
            prev_hold = stall_dec && !redir;
            for (int i = 0; i < W; i++) begin
                prev_valid[i] = out_valid[i];
                prev_pc[i] = out_pc[i];
                prev_inst[i] = out_inst[i];
            end
        end
    end

    task automatic redirect(input logic e, input addr_t et, input logic r, input addr_t rt,
                            input logic b, input addr_t bt);
        @(posedge clk);
        #1;
        excp_req = e;
        excp_target = et;
        ertn_req = r;
        ertn_target = rt;
        rob_redirect = b;
        rob_target = bt;
        @(posedge clk);
        #1;
        excp_req = 1'b0;
        ertn_req = 1'b0;
        rob_redirect = 1'b0;
    endtask

    // resolved taken branch, redirects to its target
    task automatic branch_update(input addr_t bpc, input addr_t tgt);
        @(posedge clk);
        #1;
        rob_valid = 1'b1;
        rob_is_branch = 1'b1;
        rob_taken = 1'b1;
        rob_pc = bpc;
        rob_redirect = 1'b1;
        rob_target = tgt;
        @(posedge clk);
        #1;
        rob_valid = 1'b0;
        rob_is_branch = 1'b0;
        rob_taken = 1'b0;
        rob_redirect = 1'b0;
    endtask

    task automatic wait_deliveries(input int n);
        int goal;
        goal = delivered + n;
        for (int c = 0; c < 3000 && delivered < goal; c++) begin
            @(posedge clk);
        end
        assert (delivered >= goal) else begin
            $display("timed out waiting for %0d delivered instructions", n);
            stop_on_error();
        end
    endtask

    initial begin
        // random filler never decodes as a branch
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem[w] = take_bits(32) & 32'hbfff_ffff;
        end
        mem[word_index(32'h1c00_0040)] = enc_jump(6'h14, 32'h1c00_0040, 32'h1c00_0204);
        mem[word_index(32'h1c00_021c)] = enc_jump(6'h15, 32'h1c00_021c, 32'h1c00_0600);
        mem[word_index(32'h1c00_0608)] = enc_jump(6'h14, 32'h1c00_0608, 32'h1c00_0100);
        mem[word_index(COND_PC)] = enc_beq(COND_PC, COND_TGT);
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (pc_imem == `RESET_PC) else begin
            $display("Fail pc_imem: expected %h, got %h", `RESET_PC, pc_imem);
            stop_on_error();
        end
        assert (!full && !out_valid[0]) else begin
            $display("queue not empty after reset");
            stop_on_error();
        end
        wait_deliveries(40);
        redirect(1'b0, '0, 1'b0, '0, 1'b1, COND_PC);
        wait_deliveries(10);
        redirect(1'b1, 32'h1c00_0a00, 1'b1, 32'h1c00_0b00, 1'b0, '0);
        wait_deliveries(8);
        redirect(1'b0, '0, 1'b1, 32'h1c00_0c04, 1'b1, 32'h1c00_0d00);
        wait_deliveries(6);
        // misaligned, then outside the window, then off the end
        redirect(1'b0, '0, 1'b0, '0, 1'b1, 32'h1c00_0302);
        wait_deliveries(6);
        redirect(1'b1, 32'h1c00_2000, 1'b0, '0, 1'b0, '0);
        wait_deliveries(6);
        redirect(1'b0, '0, 1'b0, '0, 1'b1, 32'h1c00_0ff0);
        wait_deliveries(8);
        branch_update(COND_PC, COND_TGT);
        wait_deliveries(6);
        redirect(1'b0, '0, 1'b0, '0, 1'b1, 32'h1c00_07f0);
        wait_deliveries(12);
        stall_mode = 2;
        redirect(1'b0, '0, 1'b0, '0, 1'b1, `RESET_PC);
        wait_deliveries(60);
        stall_mode = 1;
        wait_deliveries(80);
        stall_mode = 0;
        assert (saw_full) else begin
            $display("full never rose under stall");
            stop_on_error();
        end
        assert (saw_pred) else begin
            $display("learned branch was never delivered as predicted taken");
            stop_on_error();
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
